//--- sim.f
logic/cart_bus_pkg.sv
logic/rom_access_pkg.sv
logic/snes_strobe_sync.sv
logic/mcu_request.sv
logic/rom_access_fsm.sv
logic/rom_port.sv
logic/cart_mem_ctrl.sv
verification/psram_model.sv
verification/cart_mem_ctrl_tb.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module cart_mem_ctrl_tb -o sim_tb
	out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module cart_mem_ctrl_tb

clean:
	rm -rf obj_dir

//--- verification/cart_mem_ctrl_tb.sv
`timescale 1ns/1ns

module cart_mem_ctrl_tb;

  import cart_bus_pkg::*;
  import rom_access_pkg::*;

  localparam int NUM_CONSOLE     = 120;
  localparam int NUM_MCU         = 40;
  // Longest console write cycle plus slack
  localparam int MAX_CONSOLE_CYC = 44;
  // MCU worst case under preemption
  localparam int MAX_MCU_CYC     = 120;
  localparam int CYCLE_LIMIT     = NUM_CONSOLE * MAX_CONSOLE_CYC + NUM_MCU * MAX_MCU_CYC + 200;

  localparam snes_addr_t ROM_BASE = 24'h000400;
  localparam snes_addr_t MCU_BASE = 24'h020000;

  logic                   CLK2;
  logic                   rst_n;
  snes_addr_t             snes_addr;
  logic                   snes_read;
  logic                   snes_write;
  logic                   snes_cpu_clk;
  logic                   snes_cs;
  byte_t                  snes_data_in;
  byte_t                  snes_data_out;
  logic                   snes_databus_oe;
  logic                   snes_databus_dir;
  logic                   mcu_rrq;
  logic                   mcu_wrq;
  rom_byte_addr_t         mcu_addr;
  byte_t                  mcu_dout;
  logic                   mcu_rdy;
  byte_t                  mcu_din;
  logic [SNES_ADDR_W-2:0] rom_addr;
  logic                   rom_we;
  logic                   rom_bhe;
  logic                   rom_ble;
  rom_word_t              rom_data_out;
  logic                   rom_data_oe;
  rom_word_t              rom_data_in;

  // Expected memory contents by byte address
  byte_t       ref_bytes [int];
  logic [31:0] console_rng = 32'd53399;
  logic [31:0] mcu_rng;
  int          cycle_count = 0;
  int          error_count = 0;

  cart_mem_ctrl UUT (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_addr       (snes_addr),
    .snes_read       (snes_read),
    .snes_write      (snes_write),
    .snes_cpu_clk    (snes_cpu_clk),
    .snes_cs         (snes_cs),
    .snes_data_in    (snes_data_in),
    .snes_data_out   (snes_data_out),
    .snes_databus_oe (snes_databus_oe),
    .snes_databus_dir(snes_databus_dir),
    .mcu_rrq         (mcu_rrq),
    .mcu_wrq         (mcu_wrq),
    .mcu_addr        (mcu_addr),
    .mcu_dout        (mcu_dout),
    .mcu_rdy         (mcu_rdy),
    .mcu_din         (mcu_din),
    .rom_addr        (rom_addr),
    .rom_we          (rom_we),
    .rom_bhe         (rom_bhe),
    .rom_ble         (rom_ble),
    .rom_data_out    (rom_data_out),
    .rom_data_oe     (rom_data_oe),
    .rom_data_in     (rom_data_in)
  );

  psram_model mem_model (
    .CLK2        (CLK2),
    .rom_addr    (rom_addr),
    .rom_we      (rom_we),
    .rom_bhe     (rom_bhe),
    .rom_ble     (rom_ble),
    .rom_data_out(rom_data_out),
    .rom_data_oe (rom_data_oe),
    .rom_data_in (rom_data_in)
  );

  initial begin
    CLK2 = 1'b0;
    forever #20 CLK2 = ~CLK2;
  end

  //////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] console_rand();
    console_rng = xorshift32(console_rng);
    return console_rng;
  endfunction

  function logic [31:0] mcu_rand();
    mcu_rng = xorshift32(mcu_rng);
    return mcu_rng;
  endfunction

  // Power-up contents with even bytes in the high half of the word
  function automatic byte_t initial_byte(input snes_addr_t a);
    logic [22:0] w;
    w = a[23:1];
    if (a[0])
      return w[15:8] ^ 8'hc3;
    return w[7:0] ^ w[22:15];
  endfunction

  function automatic byte_t expected_byte(input snes_addr_t a);
    if (ref_bytes.exists(int'(a)))
      return ref_bytes[int'(a)];
    return initial_byte(a);
  endfunction

  function automatic logic in_save_window(input snes_addr_t a);
    return (a & ~DEF_SAVE_MASK) == DEF_SAVE_BASE;
  endfunction

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  //////////////////////////////////////////////////////////////
  // Console and MCU traffic
  //////////////////////////////////////////////////////////////

  task automatic console_read(input snes_addr_t a);
    int    lo_len;
    int    hi_len;
    byte_t exp_byte;
    lo_len       = 10 + int'(console_rand() % 5);
    hi_len       = 14 + int'(console_rand() % 5);
    snes_addr    = a;
    snes_cs      = 1'b0;
    snes_cpu_clk = 1'b0;
    repeat (lo_len) @(negedge CLK2);
    snes_cpu_clk = 1'b1;
    snes_read    = 1'b0;
    repeat (hi_len) @(negedge CLK2);
    // Console latches data as the CPU clock falls
    exp_byte = expected_byte(a);
    assert (snes_data_out == exp_byte)
      else report_error($sformatf("console read %06h got %02h expected %02h",
                                  a, snes_data_out, exp_byte));
    snes_read    = 1'b1;
    snes_cs      = 1'b1;
    snes_cpu_clk = 1'b0;
  endtask

  task automatic console_write(input snes_addr_t a, input byte_t d);
    int lo_len;
    lo_len       = 10 + int'(console_rand() % 5);
    snes_addr    = a;
    snes_data_in = d;
    snes_cs      = 1'b0;
    snes_cpu_clk = 1'b0;
    repeat (lo_len) @(negedge CLK2);
    snes_cpu_clk = 1'b1;
    repeat (8) @(negedge CLK2);
    snes_write = 1'b0;
    repeat (18) @(negedge CLK2);
    snes_write   = 1'b1;
    snes_cs      = 1'b1;
    snes_cpu_clk = 1'b0;
    if (in_save_window(a))
      ref_bytes[int'(a)] = d;
  endtask

  task automatic run_console();
    logic [31:0] r;
    snes_addr_t  a;
    for (int i = 0; i < NUM_CONSOLE; i++) begin
      r = console_rand();
      a = (r[8] ? DEF_SAVE_BASE : ROM_BASE) | {20'h0, r[3:0]};
      if (r[26:24] < 3'd3)
        console_write(a, r[23:16]);
      else
        console_read(a);
    end
  endtask

  task automatic mcu_access(input logic is_write, input snes_addr_t a, input byte_t d);
    mcu_addr = a;
    mcu_dout = d;
    mcu_wrq  = is_write;
    mcu_rrq  = ~is_write;
    @(negedge CLK2);
    mcu_wrq = 1'b0;
    mcu_rrq = 1'b0;
    assert (!mcu_rdy) else report_error("mcu_rdy stayed high after a request");
    while (!mcu_rdy)
      @(negedge CLK2);
  endtask

  task automatic run_mcu();
    logic [31:0] r;
    snes_addr_t  a;
    byte_t       exp_byte;
    for (int i = 0; i < NUM_MCU; i++) begin
      r = mcu_rand();
      a = MCU_BASE | {18'h0, r[5:0]};
      repeat (int'(r[31:28])) @(negedge CLK2);
      if (r[7]) begin
        mcu_access(1'b1, a, r[23:16]);
        ref_bytes[int'(a)] = r[23:16];
      end
      mcu_access(1'b0, a, 8'h00);
      exp_byte = expected_byte(a);
      assert (mcu_din == exp_byte)
        else report_error($sformatf("MCU read %06h got %02h expected %02h",
                                    a, mcu_din, exp_byte));
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////////////////

  // Strobes and chip select are settled at the rising edge
  always @(posedge CLK2) begin
    if (rst_n) begin
      assert (snes_databus_oe == !(!snes_cs && (!snes_read || !snes_write)))
        else report_error("snes_databus_oe does not follow chip select and strobes");
      assert (snes_databus_dir == !snes_read)
        else report_error("snes_databus_dir does not follow snes_read");
    end
  end

  always @(posedge CLK2) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst_n        = 1'b0;
    snes_addr    = '0;
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_cs      = 1'b1;
    snes_data_in = '0;
    mcu_rrq      = 1'b0;
    mcu_wrq      = 1'b0;
    mcu_addr     = '0;
    mcu_dout     = '0;
    // MCU stream runs far ahead in the same sequence
    mcu_rng = console_rng;
    repeat (4096) mcu_rng = xorshift32(mcu_rng);
    repeat (2) @(negedge CLK2);
    rst_n = 1'b1;
    @(negedge CLK2);
    assert (mcu_rdy && rom_we) else report_error("mcu_rdy or rom_we low after reset");
    assert (snes_data_out == 8'h00) else report_error("snes_data_out not zero after reset");
    // Let the strobe synchronizers settle
    repeat (8) @(negedge CLK2);
    fork
      run_console();
      run_mcu();
    join
    repeat (4) @(negedge CLK2);
    if (error_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- verification/psram_model.sv
`timescale 1ns/1ns

module psram_model (
  input  logic                                 CLK2,
  input  logic [cart_bus_pkg::SNES_ADDR_W-2:0] rom_addr,
  input  logic                                 rom_we,
  input  logic                                 rom_bhe,
  input  logic                                 rom_ble,
  input  cart_bus_pkg::rom_word_t              rom_data_out,
  input  logic                                 rom_data_oe,
  output cart_bus_pkg::rom_word_t              rom_data_in
);

  import cart_bus_pkg::*;

  typedef logic [SNES_ADDR_W-2:0] word_addr_t;

  // Sparse storage, untouched words read back the fill pattern
  rom_word_t mem [word_addr_t];
  int        mem_version = 0;

  function automatic rom_word_t fill_word(input word_addr_t a);
    return {a[7:0] ^ a[22:15], a[15:8] ^ 8'hc3};
  endfunction

  // Re-evaluate on address change or after any write
  always @(rom_addr or mem_version) begin
    if (mem.exists(rom_addr))
      rom_data_in = mem[rom_addr];
    else
      rom_data_in = fill_word(rom_addr);
  end

  //////////////////////////////////////////////////////////////
  // Byte-lane writes
  //////////////////////////////////////////////////////////////

  always @(posedge CLK2) begin
    rom_word_t word;
    if (!rom_we && rom_data_oe) begin
      word = mem.exists(rom_addr) ? mem[rom_addr] : fill_word(rom_addr);
      if (!rom_bhe)
        word[15:8] = rom_data_out[15:8];
      if (!rom_ble)
        word[7:0] = rom_data_out[7:0];
      mem[rom_addr] = word;
      mem_version <= mem_version + 1;
    end
  end

endmodule

//--- logic/cart_mem_ctrl.sv
`timescale 1ns/1ns

module cart_mem_ctrl #(
  parameter int                           SYNC_DEPTH    = rom_access_pkg::DEF_SYNC_DEPTH,
  parameter rom_access_pkg::wait_cnt_t    SNES_RD_WAIT  = rom_access_pkg::DEF_SNES_RD_WAIT,
  parameter rom_access_pkg::wait_cnt_t    SNES_WR_WAIT1 = rom_access_pkg::DEF_SNES_WR_WAIT1,
  parameter rom_access_pkg::wait_cnt_t    SNES_WR_WAIT2 = rom_access_pkg::DEF_SNES_WR_WAIT2,
  parameter rom_access_pkg::wait_cnt_t    MCU_WAIT      = rom_access_pkg::DEF_MCU_WAIT,
  parameter rom_access_pkg::wait_cnt_t    TAIL_WAIT     = rom_access_pkg::MCU_TAIL_WAIT,
  parameter cart_bus_pkg::rom_byte_addr_t SAVE_BASE     = rom_access_pkg::DEF_SAVE_BASE,
  parameter cart_bus_pkg::rom_byte_addr_t SAVE_MASK     = rom_access_pkg::DEF_SAVE_MASK
) (
  input  logic                                 CLK2,
  input  logic                                 rst_n,
  // Console bus
  input  cart_bus_pkg::snes_addr_t             snes_addr,
  input  logic                                 snes_read,
  input  logic                                 snes_write,
  input  logic                                 snes_cpu_clk,
  input  logic                                 snes_cs,
  input  cart_bus_pkg::byte_t                  snes_data_in,
  output cart_bus_pkg::byte_t                  snes_data_out,
  output logic                                 snes_databus_oe,
  output logic                                 snes_databus_dir,
  // MCU requests
  input  logic                                 mcu_rrq,
  input  logic                                 mcu_wrq,
  input  cart_bus_pkg::rom_byte_addr_t         mcu_addr,
  input  cart_bus_pkg::byte_t                  mcu_dout,
  output logic                                 mcu_rdy,
  output cart_bus_pkg::byte_t                  mcu_din,
  // PSRAM
  output logic [cart_bus_pkg::SNES_ADDR_W-2:0] rom_addr,
  output logic                                 rom_we,
  output logic                                 rom_bhe,
  output logic                                 rom_ble,
  output cart_bus_pkg::rom_word_t              rom_data_out,
  output logic                                 rom_data_oe,
  input  cart_bus_pkg::rom_word_t              rom_data_in
);

  import cart_bus_pkg::*;
  import rom_access_pkg::*;

  logic           cycle_start;
  logic           cycle_end;
  logic           wr_start;
  logic           rd_pend;
  logic           wr_pend;
  logic           mcu_done;
  access_state_t  state;
  rom_byte_addr_t rom_addr_reg;
  byte_t          write_byte;
  logic           rom_we_reg;
  logic           snes_wr_cycle;
  logic           need_snes_addr;
  logic           addr_bit0;

  //////////////////////////////////////////////////////////////
  // Front ends
  //////////////////////////////////////////////////////////////

  snes_strobe_sync #(
    .SYNC_DEPTH(SYNC_DEPTH)
  ) u_strobe_sync (
    .CLK2            (CLK2),
    .rst_n           (rst_n),
    .snes_read       (snes_read),
    .snes_write      (snes_write),
    .snes_cpu_clk    (snes_cpu_clk),
    .snes_cs         (snes_cs),
    .cycle_start     (cycle_start),
    .cycle_end       (cycle_end),
    .wr_start        (wr_start),
    .snes_databus_oe (snes_databus_oe),
    .snes_databus_dir(snes_databus_dir)
  );

  mcu_request u_mcu_request (
    .CLK2    (CLK2),
    .rst_n   (rst_n),
    .mcu_rrq (mcu_rrq),
    .mcu_wrq (mcu_wrq),
    .mcu_done(mcu_done),
    .rd_pend (rd_pend),
    .wr_pend (wr_pend),
    .mcu_rdy (mcu_rdy)
  );

  //////////////////////////////////////////////////////////////
  // Sequencer and PSRAM port
  //////////////////////////////////////////////////////////////

  rom_access_fsm #(
    .SNES_RD_WAIT (SNES_RD_WAIT),
    .SNES_WR_WAIT1(SNES_WR_WAIT1),
    .SNES_WR_WAIT2(SNES_WR_WAIT2),
    .MCU_WAIT     (MCU_WAIT),
    .TAIL_WAIT    (TAIL_WAIT),
    .SAVE_BASE    (SAVE_BASE),
    .SAVE_MASK    (SAVE_MASK)
  ) u_access_fsm (
    .CLK2          (CLK2),
    .rst_n         (rst_n),
    .cycle_start   (cycle_start),
    .cycle_end     (cycle_end),
    .wr_start      (wr_start),
    .rd_pend       (rd_pend),
    .wr_pend       (wr_pend),
    .snes_addr     (snes_addr),
    .mcu_addr      (mcu_addr),
    .snes_data_in  (snes_data_in),
    .mcu_dout      (mcu_dout),
    .rom_data_in   (rom_data_in),
    .addr_bit0     (addr_bit0),
    .state         (state),
    .rom_addr_reg  (rom_addr_reg),
    .write_byte    (write_byte),
    .snes_data_out (snes_data_out),
    .mcu_din       (mcu_din),
    .rom_we_reg    (rom_we_reg),
    .snes_wr_cycle (snes_wr_cycle),
    .need_snes_addr(need_snes_addr),
    .mcu_done      (mcu_done)
  );

  rom_port u_rom_port (
    .state         (state),
    .snes_addr     (snes_addr),
    .rom_addr_reg  (rom_addr_reg),
    .snes_cpu_clk  (snes_cpu_clk),
    .need_snes_addr(need_snes_addr),
    .snes_wr_cycle (snes_wr_cycle),
    .rom_we_reg    (rom_we_reg),
    .write_byte    (write_byte),
    .rom_addr      (rom_addr),
    .addr_bit0     (addr_bit0),
    .rom_we        (rom_we),
    .rom_bhe       (rom_bhe),
    .rom_ble       (rom_ble),
    .rom_data_out  (rom_data_out),
    .rom_data_oe   (rom_data_oe)
  );

endmodule

//--- logic/rom_port.sv
`timescale 1ns/1ns

module rom_port (
  input  rom_access_pkg::access_state_t          state,
  input  cart_bus_pkg::snes_addr_t               snes_addr,
  input  cart_bus_pkg::rom_byte_addr_t           rom_addr_reg,
  input  logic                                   snes_cpu_clk,
  input  logic                                   need_snes_addr,
  input  logic                                   snes_wr_cycle,
  input  logic                                   rom_we_reg,
  input  cart_bus_pkg::byte_t                    write_byte,
  output logic [cart_bus_pkg::SNES_ADDR_W-2:0]   rom_addr,
  output logic                                   addr_bit0,
  output logic                                   rom_we,
  output logic                                   rom_bhe,
  output logic                                   rom_ble,
  output cart_bus_pkg::rom_word_t                rom_data_out,
  output logic                                   rom_data_oe
);

  import cart_bus_pkg::*;
  import rom_access_pkg::*;

  logic           mcu_phase;
  logic           assert_snes_addr;
  rom_byte_addr_t byte_addr;

  assign mcu_phase = state inside {ST_MCU_RD_ADDR, ST_MCU_RD_WAIT, ST_MCU_RD_WAIT2,
                                   ST_MCU_RD_END, ST_MCU_WR_ADDR, ST_MCU_WR_WAIT,
                                   ST_MCU_WR_WAIT2, ST_MCU_WR_END};

  // Console address goes straight to the PSRAM during the CPU clock high phase,
  // but never under a running MCU access
  assign assert_snes_addr = snes_cpu_clk & need_snes_addr & ~mcu_phase;

  assign byte_addr = assert_snes_addr ? snes_addr : rom_addr_reg;
  assign rom_addr  = byte_addr[SNES_ADDR_W-1:1];
  assign addr_bit0 = byte_addr[0];

  // No stray write while a console read address is on the bus
  assign rom_we = rom_we_reg | (assert_snes_addr & ~snes_wr_cycle);

  //////////////////////////////////////////////////////////////
  // Byte lanes
  //////////////////////////////////////////////////////////////

  assign rom_data_oe  = ~rom_we;
  assign rom_data_out = addr_bit0 ? {8'h00, write_byte} : {write_byte, 8'h00};

  // Both lanes selected for reads, only the addressed one for writes
  assign rom_bhe = ~rom_we & addr_bit0;
  assign rom_ble = ~rom_we & ~addr_bit0;

endmodule

//--- logic/rom_access_fsm.sv
`timescale 1ns/1ns

module rom_access_fsm #(
  parameter rom_access_pkg::wait_cnt_t    SNES_RD_WAIT  = rom_access_pkg::DEF_SNES_RD_WAIT,
  parameter rom_access_pkg::wait_cnt_t    SNES_WR_WAIT1 = rom_access_pkg::DEF_SNES_WR_WAIT1,
  parameter rom_access_pkg::wait_cnt_t    SNES_WR_WAIT2 = rom_access_pkg::DEF_SNES_WR_WAIT2,
  parameter rom_access_pkg::wait_cnt_t    MCU_WAIT      = rom_access_pkg::DEF_MCU_WAIT,
  parameter rom_access_pkg::wait_cnt_t    TAIL_WAIT     = rom_access_pkg::MCU_TAIL_WAIT,
  parameter cart_bus_pkg::rom_byte_addr_t SAVE_BASE     = rom_access_pkg::DEF_SAVE_BASE,
  parameter cart_bus_pkg::rom_byte_addr_t SAVE_MASK     = rom_access_pkg::DEF_SAVE_MASK
) (
  input  logic                           CLK2,
  input  logic                           rst_n,
  input  logic                           cycle_start,
  input  logic                           cycle_end,
  input  logic                           wr_start,
  input  logic                           rd_pend,
  input  logic                           wr_pend,
  input  cart_bus_pkg::snes_addr_t       snes_addr,
  input  cart_bus_pkg::rom_byte_addr_t   mcu_addr,
  input  cart_bus_pkg::byte_t            snes_data_in,
  input  cart_bus_pkg::byte_t            mcu_dout,
  input  cart_bus_pkg::rom_word_t        rom_data_in,
  input  logic                           addr_bit0,
  output rom_access_pkg::access_state_t  state,
  output cart_bus_pkg::rom_byte_addr_t   rom_addr_reg,
  output cart_bus_pkg::byte_t            write_byte,
  output cart_bus_pkg::byte_t            snes_data_out,
  output cart_bus_pkg::byte_t            mcu_din,
  output logic                           rom_we_reg,
  output logic                           snes_wr_cycle,
  output logic                           need_snes_addr,
  output logic                           mcu_done
);

  import cart_bus_pkg::*;
  import rom_access_pkg::*;

  wait_cnt_t delay;
  logic      console_go;
  logic      in_save_window;
  byte_t     lane_byte;

  assign console_go     = cycle_start | wr_start;
  assign in_save_window = ((rom_addr_reg & ~SAVE_MASK) == (SAVE_BASE & ~SAVE_MASK));
  // Even address sits in the high byte
  assign lane_byte      = addr_bit0 ? rom_data_in[7:0] : rom_data_in[15:8];
  assign mcu_done       = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  //////////////////////////////////////////////////////////////
  // Access sequencer
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state         <= ST_IDLE;
      delay         <= '0;
      rom_we_reg    <= 1'b1;
      snes_wr_cycle <= 1'b0;
    end else if (console_go) begin
      // Console preempts anything, pending flag restarts an aborted MCU access
      state         <= wr_start ? ST_SNES_WR_ADDR : ST_SNES_RD_ADDR;
      rom_we_reg    <= 1'b1;
      snes_wr_cycle <= wr_start;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rd_pend)
            state <= ST_MCU_RD_ADDR;
          else if (wr_pend)
            state <= ST_MCU_WR_ADDR;
        end
        ST_SNES_RD_ADDR: begin
          state <= ST_SNES_RD_WAIT;
          delay <= SNES_RD_WAIT;
        end
        ST_SNES_RD_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == '0)
            state <= ST_SNES_RD_END;
        end
        ST_SNES_WR_ADDR: begin
          state <= ST_SNES_WR_WAIT1;
          delay <= SNES_WR_WAIT1;
        end
        ST_SNES_WR_WAIT1: begin
          delay <= delay - 4'd1;
          if (delay == '0)
            state <= ST_SNES_WR_DATA;
        end
        ST_SNES_WR_DATA: begin
          state      <= ST_SNES_WR_WAIT2;
          delay      <= SNES_WR_WAIT2;
          // Only the save area is writable from the console
          rom_we_reg <= ~in_save_window;
        end
        ST_SNES_WR_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == '0)
            state <= ST_SNES_WR_END;
        end
        ST_SNES_WR_END: begin
          state         <= ST_IDLE;
          rom_we_reg    <= 1'b1;
          snes_wr_cycle <= 1'b0;
        end
        ST_MCU_RD_ADDR: begin
          state <= ST_MCU_RD_WAIT;
          delay <= MCU_WAIT;
        end
        ST_MCU_RD_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == '0) begin
            state <= ST_MCU_RD_WAIT2;
            delay <= TAIL_WAIT;
          end
        end
        ST_MCU_RD_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == '0)
            state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          state      <= ST_MCU_WR_WAIT;
          delay      <= MCU_WAIT;
          rom_we_reg <= 1'b0;
        end
        ST_MCU_WR_WAIT: begin
          delay <= delay - 4'd1;
          if (delay == '0) begin
            state      <= ST_MCU_WR_WAIT2;
            delay      <= TAIL_WAIT;
            rom_we_reg <= 1'b1;
          end
        end
        ST_MCU_WR_WAIT2: begin
          delay <= delay - 4'd1;
          if (delay == '0)
            state <= ST_MCU_WR_END;
        end
        // End states
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Console address wanted from the falling CPU clock until the access is done
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n)
      need_snes_addr <= 1'b0;
    else if (cycle_end)
      need_snes_addr <= 1'b1;
    else if (state == ST_SNES_RD_END || state == ST_SNES_WR_END)
      need_snes_addr <= 1'b0;
  end

  //////////////////////////////////////////////////////////////
  // Address, write data and read capture
  //////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (console_go || state == ST_IDLE)
      rom_addr_reg <= snes_addr;
    else if (state == ST_MCU_RD_ADDR || state == ST_MCU_WR_ADDR)
      rom_addr_reg <= mcu_addr;
    if (state == ST_SNES_WR_DATA)
      write_byte <= snes_data_in;
    else if (state == ST_MCU_WR_ADDR)
      write_byte <= mcu_dout;
  end

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_data_out <= '0;
      mcu_din       <= '0;
    end else begin
      if (state == ST_SNES_RD_WAIT || state == ST_SNES_RD_END)
        snes_data_out <= lane_byte;
      if (state == ST_MCU_RD_WAIT)
        mcu_din <= lane_byte;
    end
  end

endmodule

//--- logic/mcu_request.sv
`timescale 1ns/1ns

module mcu_request (
  input  logic CLK2,
  input  logic rst_n,
  input  logic mcu_rrq,
  input  logic mcu_wrq,
  input  logic mcu_done,
  output logic rd_pend,
  output logic wr_pend,
  output logic mcu_rdy
);

  // Request pulses win over completion, read before write
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

endmodule

//--- logic/snes_strobe_sync.sv
`timescale 1ns/1ns

module snes_strobe_sync #(
  parameter int SYNC_DEPTH = rom_access_pkg::DEF_SYNC_DEPTH
) (
  input  logic CLK2,
  input  logic rst_n,
  input  logic snes_read,
  input  logic snes_write,
  input  logic snes_cpu_clk,
  input  logic snes_cs,
  output logic cycle_start,
  output logic cycle_end,
  output logic wr_start,
  output logic snes_databus_oe,
  output logic snes_databus_dir
);

  // Oldest sample in the MSB, new level stable in all the others
  localparam logic [SYNC_DEPTH-1:0] RISE_PAT = {1'b0, {(SYNC_DEPTH-1){1'b1}}};
  localparam logic [SYNC_DEPTH-1:0] FALL_PAT = {1'b1, {(SYNC_DEPTH-1){1'b0}}};

  logic [SYNC_DEPTH-1:0] cpu_clk_sr;
  logic [SYNC_DEPTH-1:0] write_sr;

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      cpu_clk_sr <= '1;
      write_sr   <= '1;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk};
      write_sr   <= {write_sr[SYNC_DEPTH-2:0], snes_write};
    end
  end

  assign cycle_start = (cpu_clk_sr == RISE_PAT);
  assign cycle_end   = (cpu_clk_sr == FALL_PAT);
  assign wr_start    = (write_sr == FALL_PAT);

  // Bus transceiver follows the raw strobes
  assign snes_databus_oe  = snes_cs | (snes_read & snes_write);
  assign snes_databus_dir = ~snes_read;

endmodule

//--- logic/rom_access_pkg.sv
package rom_access_pkg;

  // One-hot sequencer states
  typedef enum logic [16:0] {
    ST_IDLE          = 17'h00001,
    ST_SNES_RD_ADDR  = 17'h00002,
    ST_SNES_RD_WAIT  = 17'h00004,
    ST_SNES_RD_END   = 17'h00008,
    ST_SNES_WR_ADDR  = 17'h00010,
    ST_SNES_WR_WAIT1 = 17'h00020,
    ST_SNES_WR_DATA  = 17'h00040,
    ST_SNES_WR_WAIT2 = 17'h00080,
    ST_SNES_WR_END   = 17'h00100,
    ST_MCU_RD_ADDR   = 17'h00200,
    ST_MCU_RD_WAIT   = 17'h00400,
    ST_MCU_RD_WAIT2  = 17'h00800,
    ST_MCU_RD_END    = 17'h01000,
    ST_MCU_WR_ADDR   = 17'h02000,
    ST_MCU_WR_WAIT   = 17'h04000,
    ST_MCU_WR_WAIT2  = 17'h08000,
    ST_MCU_WR_END    = 17'h10000
  } access_state_t;

  typedef logic [3:0] wait_cnt_t;

  // Counter loads these and runs down to zero inclusive
  localparam wait_cnt_t DEF_SNES_RD_WAIT  = 4'd4;
  localparam wait_cnt_t DEF_SNES_WR_WAIT1 = 4'd2;
  localparam wait_cnt_t DEF_SNES_WR_WAIT2 = 4'd3;
  localparam wait_cnt_t DEF_MCU_WAIT      = 4'd6;
  localparam wait_cnt_t MCU_TAIL_WAIT     = 4'd2;
  localparam int        DEF_SYNC_DEPTH    = 6;

  // Writable save area, 8 KB at 0x700000
  localparam logic [23:0] DEF_SAVE_BASE = 24'h700000;
  localparam logic [23:0] DEF_SAVE_MASK = 24'h001fff;

endpackage

//--- logic/cart_bus_pkg.sv
package cart_bus_pkg;

  // Console address and PSRAM data widths
  localparam int SNES_ADDR_W = 24;
  localparam int ROM_DATA_W  = 16;

  // Console side byte address
  typedef logic [SNES_ADDR_W-1:0] snes_addr_t;

  // PSRAM byte address, bit 0 picks the lane
  typedef logic [SNES_ADDR_W-1:0] rom_byte_addr_t;

  typedef logic [ROM_DATA_W-1:0] rom_word_t;

  typedef logic [7:0] byte_t;

endpackage
